// ==== logic/cdc_pkg.sv ====
package cdc_pkg;

  localparam int nibble_w     = 4;
  localparam int word_w       = 2 * nibble_w;
  localparam int fifo_depth   = 16;
  localparam int addr_w       = $clog2(fifo_depth);
  localparam int afull_level  = 14;
  localparam int aempty_level = 1;

  // Pointer with one extra wrap bit
  typedef logic [addr_w:0] ptr_t;

  typedef enum logic {
    low_half,
    high_half
  } half_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[addr_w] = gray[addr_w];
    for (int i = addr_w - 1; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== logic/dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram import cdc_pkg::*; (
  input  logic              wr_clk,
  input  logic              wr_en,
  input  logic [addr_w-1:0] wr_addr,
  input  logic [word_w-1:0] wr_data,
  input  logic              rd_clk,
  input  logic              rd_en,
  input  logic [addr_w-1:0] rd_addr,
  output logic [word_w-1:0] rd_data
);

  logic [word_w-1:0] mem [fifo_depth];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Output holds its last word between reads
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== logic/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps

module fifo_wr_ctrl import cdc_pkg::*; (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_en,
  input  ptr_t              rd_ptr_gray,
  output ptr_t              wr_ptr_gray,
  output logic [addr_w-1:0] wr_addr,
  output logic              wr_accept,
  output logic              full,
  output logic              afull
);

  ptr_t wr_ptr_bin;
  ptr_t wr_ptr_next;
  ptr_t rd_gray_s1;
  ptr_t rd_gray_s2;
  ptr_t rd_ptr_sync;
  ptr_t used_next;

  assign wr_accept   = wr_en && !full;
  assign wr_ptr_next = wr_ptr_bin + ptr_t'(wr_accept);
  assign wr_addr     = wr_ptr_bin[addr_w-1:0];

  // Read pointer into the write domain
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_ptr_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_ptr_sync = gray2bin(rd_gray_s2);
  assign used_next   = wr_ptr_next - rd_ptr_sync;

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_ptr_bin  <= wr_ptr_next;
      wr_ptr_gray <= bin2gray(wr_ptr_next);
      full        <= (used_next == ptr_t'(fifo_depth));
      afull       <= (used_next >= ptr_t'(afull_level));
    end
  end

endmodule

// ==== logic/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps

module fifo_rd_ctrl import cdc_pkg::*; (
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  input  ptr_t              wr_ptr_gray,
  output ptr_t              rd_ptr_gray,
  output logic [addr_w-1:0] rd_addr,
  output logic              rd_accept,
  output logic              empty,
  output logic              aempty
);

  ptr_t rd_ptr_bin;
  ptr_t rd_ptr_next;
  ptr_t wr_gray_s1;
  ptr_t wr_gray_s2;
  ptr_t wr_ptr_sync;
  ptr_t used_next;

  assign rd_accept   = rd_en && !empty;
  assign rd_ptr_next = rd_ptr_bin + ptr_t'(rd_accept);
  assign rd_addr     = rd_ptr_bin[addr_w-1:0];

  // Write pointer into the read domain
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_ptr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_ptr_sync = gray2bin(wr_gray_s2);
  assign used_next   = wr_ptr_sync - rd_ptr_next;

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
    end else begin
      rd_ptr_bin  <= rd_ptr_next;
      rd_ptr_gray <= bin2gray(rd_ptr_next);
      empty       <= (used_next == '0);
      aempty      <= (used_next <= ptr_t'(aempty_level));
    end
  end

endmodule

// ==== logic/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo import cdc_pkg::*; (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_en,
  input  logic [word_w-1:0] wr_data,
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  output logic [word_w-1:0] rd_data,
  output logic              full,
  output logic              afull,
  output logic              empty,
  output logic              aempty
);

  ptr_t              wr_ptr_gray;
  ptr_t              rd_ptr_gray;
  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  logic              wr_accept;
  logic              rd_accept;

  fifo_wr_ctrl u_fifo_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_addr     (wr_addr),
    .wr_accept   (wr_accept),
    .full        (full),
    .afull       (afull)
  );

  fifo_rd_ctrl u_fifo_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_addr     (rd_addr),
    .rd_accept   (rd_accept),
    .empty       (empty),
    .aempty      (aempty)
  );

  // Only accepted strobes reach the RAM
  dual_port_ram u_dual_port_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_accept),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_accept),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// ==== logic/nibble_packer.sv ====
`timescale 1ns/1ps

module nibble_packer import cdc_pkg::*; (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                in_valid,
  input  logic [nibble_w-1:0] in_nibble,
  input  logic                full,
  output logic                wr_en,
  output logic [word_w-1:0]   wr_data,
  output logic                overflow
);

  half_t               state;
  logic [nibble_w-1:0] low_nibble;

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      state    <= low_half;
      wr_en    <= 1'b0;
      overflow <= 1'b0;
    end else begin
      wr_en <= in_valid && (state == high_half);
      if (in_valid) begin
        state <= (state == low_half) ? high_half : low_half;
      end
      // Sticky until reset
      if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (in_valid && state == low_half) begin
      low_nibble <= in_nibble;
    end
    if (in_valid && state == high_half) begin
      wr_data <= {in_nibble, low_nibble};
    end
  end

endmodule

// ==== logic/nibble_unpacker.sv ====
`timescale 1ns/1ps

module nibble_unpacker import cdc_pkg::*; (
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                empty,
  input  logic [word_w-1:0]   rd_data,
  output logic                rd_en,
  output logic                out_valid,
  output logic [nibble_w-1:0] out_nibble
);

  half_t               state;
  // rd_data holds a word not yet emitted
  logic                pending;
  logic [nibble_w-1:0] high_nibble;

  // No new read while the high nibble goes out
  assign rd_en = !empty && (state == low_half);

  assign out_valid  = (pending && state == low_half) || (state == high_half);
  assign out_nibble = (state == high_half) ? high_nibble : rd_data[nibble_w-1:0];

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      state   <= low_half;
      pending <= 1'b0;
    end else begin
      if (state == high_half) begin
        state <= low_half;
      end else begin
        pending <= rd_en;
        if (pending) begin
          state <= high_half;
        end
      end
    end
  end

  // Keep the high half before the next word lands on rd_data
  always_ff @(posedge rd_clk) begin
    if (pending && state == low_half) begin
      high_nibble <= rd_data[word_w-1:nibble_w];
    end
  end

endmodule

// ==== logic/nibble_cdc_top.sv ====
`timescale 1ns/1ps

module nibble_cdc_top import cdc_pkg::*; (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                in_valid,
  input  logic [nibble_w-1:0] in_nibble,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  output logic                in_full,
  output logic                in_afull,
  output logic                overflow,
  output logic                out_valid,
  output logic [nibble_w-1:0] out_nibble
);

  logic              wr_en;
  logic [word_w-1:0] wr_data;
  logic              rd_en;
  logic [word_w-1:0] rd_data;
  logic              empty;

  nibble_packer u_nibble_packer (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .in_valid  (in_valid),
    .in_nibble (in_nibble),
    .full      (in_full),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .overflow  (overflow)
  );

  async_fifo u_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (in_full),
    .afull    (in_afull),
    .empty    (empty),
    .aempty   ()
  );

  nibble_unpacker u_nibble_unpacker (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .empty      (empty),
    .rd_data    (rd_data),
    .rd_en      (rd_en),
    .out_valid  (out_valid),
    .out_nibble (out_nibble)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns  = 20,
  parameter int rst_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2);
      clk = ~clk;
    end
  end

  // Release lands just after an edge, like other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

// ==== test/nibble_cdc_chk.sv ====
`timescale 1ns/1ps

module nibble_cdc_chk import cdc_pkg::*; (
  input logic wr_clk,
  input logic wr_rst_n,
  input logic rd_clk,
  input logic rd_rst_n,
  input logic wr_accept,
  input logic rd_accept,
  input ptr_t wr_ptr_gray,
  input ptr_t rd_ptr_gray
);

  // Live pointers of both sides, not the synchronized copies
  write_not_full_a: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
      wr_accept |->
        wr_ptr_gray != {~rd_ptr_gray[addr_w:addr_w-1], rd_ptr_gray[addr_w-2:0]}
  ) else $error("RAM write while FIFO full");

  read_not_empty_a: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      rd_accept |-> rd_ptr_gray != wr_ptr_gray
  ) else $error("RAM read while FIFO empty");

  // Gray pointers must cross with a single bit change
  wr_gray_step_a: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
      $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
  ) else $error("Write Gray pointer changed more than one bit");

  rd_gray_step_a: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1
  ) else $error("Read Gray pointer changed more than one bit");

endmodule

bind async_fifo nibble_cdc_chk u_nibble_cdc_chk (
  .wr_clk      (wr_clk),
  .wr_rst_n    (wr_rst_n),
  .rd_clk      (rd_clk),
  .rd_rst_n    (rd_rst_n),
  .wr_accept   (wr_accept),
  .rd_accept   (rd_accept),
  .wr_ptr_gray (wr_ptr_gray),
  .rd_ptr_gray (rd_ptr_gray)
);

// ==== test/nibble_cdc_tb.sv ====
`timescale 1ns/1ps

module nibble_cdc_tb import cdc_pkg::*; ();

  localparam logic [31:0] lcg_seed = 32'd62;
  localparam int drive_delay   = 2;
  localparam int rand_nibbles  = 200;
  localparam int reset_timeout = 20;
  localparam int flag_timeout  = 200;
  localparam int drain_timeout = 2000;

  logic                wr_clk;
  logic                rd_clk;
  logic                wr_gen_rst_n;
  logic                rd_gen_rst_n;
  logic                wr_hold_n;
  logic                rd_hold_n;
  logic                wr_rst_n;
  logic                rd_rst_n;
  logic                in_valid;
  logic [nibble_w-1:0] in_nibble;
  logic                in_full;
  logic                in_afull;
  logic                overflow;
  logic                out_valid;
  logic [nibble_w-1:0] out_nibble;

  // Every nibble the DUT should pass on, in input order
  logic [nibble_w-1:0] in_hist [$];
  logic [nibble_w-1:0] exp_nib;
  logic [31:0]         lcg_state;
  logic [31:0]         rnd;
  int                  out_count;
  int                  quiet_start;
  int                  data_errs;
  int                  check_errs;
  int                  timeouts;

  tb_clk_gen #(.period_ns(20), .rst_cycles(4)) u_wr_clk_gen (
    .clk   (wr_clk),
    .rst_n (wr_gen_rst_n)
  );

  tb_clk_gen #(.period_ns(28), .rst_cycles(4)) u_rd_clk_gen (
    .clk   (rd_clk),
    .rst_n (rd_gen_rst_n)
  );

  assign wr_rst_n = wr_gen_rst_n && wr_hold_n;
  assign rd_rst_n = rd_gen_rst_n && rd_hold_n;

  nibble_cdc_top u_nibble_cdc_top (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .in_valid   (in_valid),
    .in_nibble  (in_nibble),
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .in_full    (in_full),
    .in_afull   (in_afull),
    .overflow   (overflow),
    .out_valid  (out_valid),
    .out_nibble (out_nibble)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Output idx comes from word idx/2, low half first
  function automatic logic [nibble_w-1:0] expected_nibble(input int idx);
    logic [word_w-1:0] word;
    int                base;
    base = 2 * (idx / 2);
    word = {in_hist[base + 1], in_hist[base]};
    if (idx % 2 == 0) begin
      return word[nibble_w-1:0];
    end
    return word[word_w-1:nibble_w];
  endfunction

  function automatic logic flag_level(input string name);
    if (name == "in_full") begin
      return in_full;
    end else if (name == "in_afull") begin
      return in_afull;
    end
    return overflow;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge wr_clk);
      #drive_delay;
    end
  endtask

  task automatic send_nibble(input logic [nibble_w-1:0] nib, input bit keep);
    in_valid  = 1'b1;
    in_nibble = nib;
    if (keep) begin
      in_hist.push_back(nib);
    end
    idle_cycles(1);
    in_valid = 1'b0;
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
      check_errs++;
    end
  endtask

  task automatic await_flag(input string name, input logic level);
    int cycles;
    cycles = 0;
    while (flag_level(name) !== level && cycles < flag_timeout) begin
      idle_cycles(1);
      cycles++;
    end
    if (flag_level(name) !== level) begin
      $display("Timeout: %s did not reach %b within %0d write cycles",
               name, level, flag_timeout);
      timeouts++;
    end
  endtask

  task automatic await_outputs(input int target);
    int cycles;
    cycles = 0;
    while (out_count < target && cycles < drain_timeout) begin
      @(posedge rd_clk);
      #1;
      cycles++;
    end
    if (out_count < target) begin
      $display("Timeout: only %0d of %0d nibbles came out", out_count, target);
      timeouts++;
    end
    idle_cycles(1);
  endtask

  task automatic await_reset_release();
    int cycles;
    cycles = 0;
    while ((!wr_rst_n || !rd_rst_n) && cycles < reset_timeout) begin
      idle_cycles(1);
      cycles++;
    end
    if (!wr_rst_n || !rd_rst_n) begin
      $display("Timeout: resets were never released");
      timeouts++;
    end
  endtask

  always @(posedge rd_clk) begin
    if (out_valid) begin
      if (2 * (out_count / 2) + 1 >= in_hist.size()) begin
        $display("Unexpected nibble %h at %0t with no input left to match", out_nibble, $time);
        check_errs++;
      end else begin
        exp_nib = expected_nibble(out_count);
        if (out_nibble !== exp_nib) begin
          $display("ERR %0t out_nibble expected %h got %h", $time, exp_nib, out_nibble);
          data_errs++;
        end
      end
      out_count++;
    end
  end

  initial begin
    in_valid   = 1'b0;
    in_nibble  = '0;
    wr_hold_n  = 1'b1;
    rd_hold_n  = 1'b1;
    lcg_state  = lcg_seed;
    out_count  = 0;
    data_errs  = 0;
    check_errs = 0;
    timeouts   = 0;

    await_reset_release();
    check_level("in_full", in_full, 1'b0);
    check_level("in_afull", in_afull, 1'b0);
    check_level("overflow", overflow, 1'b0);
    check_level("out_valid", out_valid, 1'b0);

    // Random stream, source backs off on afull
    for (int i = 0; i < rand_nibbles; i++) begin
      await_flag("in_afull", 1'b0);
      rnd = lcg_next();
      send_nibble(rnd[31:28], 1'b1);
      idle_cycles(int'(rnd[27:26]));
    end
    await_outputs(in_hist.size());
    check_level("overflow", overflow, 1'b0);

    // Read side first, so it never sees a stale write pointer
    @(posedge rd_clk);
    #drive_delay;
    rd_hold_n = 1'b0;
    idle_cycles(1);
    wr_hold_n = 1'b0;
    idle_cycles(4);
    wr_hold_n = 1'b1;

    for (int i = 0; i < 2 * afull_level; i++) begin
      rnd = lcg_next();
      send_nibble(rnd[31:28], 1'b1);
    end
    await_flag("in_afull", 1'b1);
    check_level("in_full", in_full, 1'b0);
    for (int i = 0; i < 2 * (fifo_depth - afull_level); i++) begin
      rnd = lcg_next();
      send_nibble(rnd[31:28], 1'b1);
    end
    await_flag("in_full", 1'b1);
    check_level("overflow", overflow, 1'b0);

    // This pair is dropped by the full FIFO
    send_nibble(4'ha, 1'b0);
    send_nibble(4'h5, 1'b0);
    await_flag("overflow", 1'b1);

    @(posedge rd_clk);
    #drive_delay;
    rd_hold_n = 1'b1;
    await_outputs(in_hist.size());
    await_flag("in_full", 1'b0);
    await_flag("in_afull", 1'b0);
    quiet_start = out_count;
    idle_cycles(20);
    if (out_count != quiet_start) begin
      $display("Output kept coming after the stored nibbles were drained");
      check_errs++;
    end
    check_level("overflow", overflow, 1'b1);

    $display("Errors: data %0d, checks %0d, timeouts %0d", data_errs, check_errs, timeouts);
    if (data_errs + check_errs + timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== nibble_cdc_top.f ====
logic/cdc_pkg.sv
logic/dual_port_ram.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/async_fifo.sv
logic/nibble_packer.sv
logic/nibble_unpacker.sv
logic/nibble_cdc_top.sv
test/tb_clk_gen.sv
test/nibble_cdc_chk.sv
test/nibble_cdc_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := nibble_cdc_tb
FILELIST  := nibble_cdc_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
